//--- hdl/rv_pkg.sv
`default_nettype none

package rv_pkg;

    typedef logic [31:0] data_t;       // Data word
    typedef logic [31:0] inst_addr_t;  // Byte address
    typedef logic [4:0]  reg_addr_t;   // Register index
    typedef logic [3:0]  byte_en_t;    // One bit per byte lane

    // Size of a load or store
    typedef enum logic [1:0] {
        ACCESS_BYTE = 2'd0,            // 8 bits
        ACCESS_HALF = 2'd1,            // 16 bits
        ACCESS_WORD = 2'd2             // 32 bits and reset value
    } mem_access_e;

    // Source of the register write-back value
    typedef enum logic [1:0] {
        WB_RESULT = 2'd0,              // ALU result
        WB_LOAD   = 2'd1,              // Extended load data
        WB_LINK   = 2'd2               // Return address pc + 4
    } wb_sel_e;

endpackage

`default_nettype wire

//--- hdl/pipeline_ex_mem.sv
`timescale 1ns/10ps
`default_nettype none

module pipeline_ex_mem
    import rv_pkg::*;
(
    input  logic        i_clock,
    input  logic        i_rst_n,
    input  logic        i_stall,            // Keep current state
    input  logic        i_flush,            // Load a no-op
    input  inst_addr_t  i_pc,
    input  data_t       i_result,
    input  data_t       i_data_b,
    input  logic        i_mem_wr_enable,
    input  logic        i_mem_rd_enable,
    input  mem_access_e i_mem_access,
    input  logic        i_mem_unsigned,
    input  reg_addr_t   i_reg_wr_addr,
    input  logic        i_reg_wr_enable,
    input  wb_sel_e     i_reg_wr_data_sel,
    output inst_addr_t  o_pc,
    output data_t       o_result,
    output data_t       o_data_b,
    output logic        o_mem_wr_enable,
    output logic        o_mem_rd_enable,
    output mem_access_e o_mem_access,
    output logic        o_mem_unsigned,
    output reg_addr_t   o_reg_wr_addr,
    output logic        o_reg_wr_enable,
    output wb_sel_e     o_reg_wr_data_sel
);

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_pc              <= '0;
            o_result          <= '0;
            o_data_b          <= '0;
            o_mem_wr_enable   <= 1'b0;
            o_mem_rd_enable   <= 1'b0;
            o_mem_access      <= ACCESS_WORD;      // Word is the idle size
            o_mem_unsigned    <= 1'b0;
            o_reg_wr_addr     <= '0;
            o_reg_wr_enable   <= 1'b0;
            o_reg_wr_data_sel <= WB_RESULT;
        end else if (i_flush || !i_stall) begin    // Flush beats stall
            o_pc              <= i_pc;
            o_result          <= i_result;
            o_data_b          <= i_data_b;
            o_mem_wr_enable   <= i_mem_wr_enable & ~i_flush;
            o_mem_rd_enable   <= i_mem_rd_enable & ~i_flush;
            o_mem_access      <= i_mem_access;
            o_mem_unsigned    <= i_mem_unsigned;
            o_reg_wr_addr     <= i_reg_wr_addr;
            o_reg_wr_enable   <= i_reg_wr_enable & ~i_flush;
            o_reg_wr_data_sel <= i_reg_wr_data_sel;
        end
    end

    // Flushed slot carries no side effect into MEM
    a_flush_nop: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        i_flush |=> !o_mem_wr_enable && !o_reg_wr_enable);

endmodule

`default_nettype wire

//--- hdl/load_store_unit.sv
`timescale 1ns/10ps
`default_nettype none

module load_store_unit
    import rv_pkg::*;
(
    input  logic        i_clock,
    input  logic        i_rst_n,
    input  inst_addr_t  i_addr,             // Byte address from ALU result
    input  data_t       i_store_data,
    input  mem_access_e i_access,
    input  logic        i_unsigned,
    input  logic        i_rd_enable,
    input  logic        i_wr_enable,
    input  data_t       i_ram_rdata,        // Word read one cycle ago
    output logic        o_req,
    output logic        o_write,
    output inst_addr_t  o_word_index,
    output byte_en_t    o_byte_en,
    output data_t       o_wdata,
    output data_t       o_load_data,
    output logic        o_misaligned
);

    logic        access;                    // Load or store present
    logic        bad_align;
    logic [1:0]  offset_q;                  // Load format of last cycle
    mem_access_e access_q;
    logic        unsigned_q;
    data_t       shifted;                   // Addressed field at bit 0

    assign access = i_rd_enable | i_wr_enable;

    always_comb begin
        case (i_access)
            ACCESS_BYTE: bad_align = 1'b0;
            ACCESS_HALF: bad_align = i_addr[0];
            default:     bad_align = |i_addr[1:0];
        endcase
    end

    assign o_misaligned = access & bad_align;              // Blocked access
    assign o_req        = access & ~bad_align;
    assign o_write      = i_wr_enable & ~bad_align;
    assign o_word_index = {2'b00, i_addr[31:2]};

    always_comb begin
        case (i_access)
            ACCESS_BYTE: begin
                o_byte_en = byte_en_t'(4'b0001 << i_addr[1:0]);
                o_wdata   = {4{i_store_data[7:0]}};        // Copy to all lanes
            end
            ACCESS_HALF: begin
                o_byte_en = i_addr[1] ? 4'b1100 : 4'b0011;
                o_wdata   = {2{i_store_data[15:0]}};
            end
            default: begin
                o_byte_en = 4'b1111;
                o_wdata   = i_store_data;
            end
        endcase
    end

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            offset_q   <= 2'b00;
            access_q   <= ACCESS_WORD;
            unsigned_q <= 1'b0;
        end else begin                      // Track request one cycle behind
            offset_q   <= i_addr[1:0];
            access_q   <= i_access;
            unsigned_q <= i_unsigned;
        end
    end

    assign shifted = i_ram_rdata >> {offset_q, 3'b000};

    always_comb begin
        case (access_q)
            ACCESS_BYTE: o_load_data = {{24{shifted[7] & ~unsigned_q}}, shifted[7:0]};
            ACCESS_HALF: o_load_data = {{16{shifted[15] & ~unsigned_q}}, shifted[15:0]};
            default:     o_load_data = shifted;
        endcase
    end

    // A slot carries either a load or a store
    a_one_access: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        !(i_rd_enable && i_wr_enable));

endmodule

`default_nettype wire

//--- hdl/mem_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module mem_arbiter
    import rv_pkg::*;
#(
    parameter int RAM_WORDS = 1024          // Power of two
)(
    input  logic       i_clock,
    input  logic       i_rst_n,
    input  logic       i_data_req,
    input  logic       i_data_write,
    input  inst_addr_t i_data_index,        // Word index
    input  byte_en_t   i_data_byte_en,
    input  data_t      i_data_wdata,
    input  logic       i_fetch_req,
    input  inst_addr_t i_fetch_addr,        // Byte address
    input  data_t      i_ram_rdata,
    output logic       o_fetch_grant,
    output logic       o_fetch_valid,
    output data_t      o_fetch_data,
    output data_t      o_data_rdata,
    output logic       o_ram_enable,
    output logic       o_ram_write,
    output inst_addr_t o_ram_index,
    output byte_en_t   o_ram_byte_en,
    output data_t      o_ram_wdata
);

    localparam int IDX_W = $clog2(RAM_WORDS);

    logic [IDX_W-1:0] ram_idx;              // Index within RAM depth
    logic             fetch_owner_q;        // Fetch held port last cycle

    assign o_fetch_grant = i_fetch_req & ~i_data_req;      // Data always first
    assign o_ram_enable  = i_data_req | i_fetch_req;
    assign o_ram_write   = i_data_req & i_data_write;      // Fetch only reads
    assign ram_idx       = i_data_req ? i_data_index[IDX_W-1:0]
                                      : i_fetch_addr[IDX_W+1:2];
    assign o_ram_index   = inst_addr_t'(ram_idx);
    assign o_ram_byte_en = i_data_req ? i_data_byte_en : 4'b1111;
    assign o_ram_wdata   = i_data_wdata;

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n)
            fetch_owner_q <= 1'b0;
        else
            fetch_owner_q <= o_fetch_grant;
    end

    assign o_fetch_valid = fetch_owner_q;
    assign o_fetch_data  = fetch_owner_q ? i_ram_rdata : '0;  // Route by owner
    assign o_data_rdata  = fetch_owner_q ? '0 : i_ram_rdata;

    // Fetch reads a full word at a word address
    a_fetch_aligned: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        i_fetch_req |-> i_fetch_addr[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- hdl/unified_ram.sv
`timescale 1ns/10ps
`default_nettype none

module unified_ram
    import rv_pkg::*;
#(
    parameter int RAM_WORDS = 1024
)(
    input  logic       i_clock,
    input  logic       i_enable,            // Port access this cycle
    input  logic       i_write,
    input  inst_addr_t i_index,             // Word index
    input  byte_en_t   i_byte_en,
    input  data_t      i_wdata,
    output data_t      o_rdata              // Old word on write
);

    localparam int IDX_W = $clog2(RAM_WORDS);

    data_t            mem [RAM_WORDS];      // Contents not reset
    logic [IDX_W-1:0] idx;

    assign idx = i_index[IDX_W-1:0];

    always_ff @(posedge i_clock) begin
        if (i_enable) begin
            if (i_write) begin
                for (int b = 0; b < 4; b++) begin
                    if (i_byte_en[b])
                        mem[idx][b*8 +: 8] <= i_wdata[b*8 +: 8];  // Lane write
                end
            end
            o_rdata <= mem[idx];            // Registered read
        end
    end

endmodule

`default_nettype wire

//--- hdl/writeback_stage.sv
`timescale 1ns/10ps
`default_nettype none

module writeback_stage
    import rv_pkg::*;
(
    input  logic       i_clock,
    input  logic       i_rst_n,
    input  inst_addr_t i_pc,
    input  data_t      i_result,
    input  reg_addr_t  i_reg_wr_addr,
    input  logic       i_reg_wr_enable,
    input  wb_sel_e    i_reg_wr_data_sel,
    input  data_t      i_load_data,         // Arrives with registered fields
    output logic       o_wb_enable,
    output reg_addr_t  o_wb_addr,
    output data_t      o_wb_data
);

    inst_addr_t pc_q;
    data_t      result_q;
    wb_sel_e    sel_q;

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc_q        <= '0;
            result_q    <= '0;
            sel_q       <= WB_RESULT;
            o_wb_addr   <= '0;
            o_wb_enable <= 1'b0;
        end else begin
            pc_q        <= i_pc;
            result_q    <= i_result;
            sel_q       <= i_reg_wr_data_sel;
            o_wb_addr   <= i_reg_wr_addr;
            o_wb_enable <= i_reg_wr_enable && (i_reg_wr_addr != '0);  // x0 stays zero
        end
    end

    always_comb begin
        case (sel_q)
            WB_LOAD: o_wb_data = i_load_data;
            WB_LINK: o_wb_data = pc_q + 32'd4;  // Return address
            default: o_wb_data = result_q;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/rv_mem_subsystem.sv
`timescale 1ns/10ps
`default_nettype none

module rv_mem_subsystem
    import rv_pkg::*;
#(
    parameter int RAM_WORDS = 1024
)(
    input  logic        i_clock,
    input  logic        i_rst_n,
    input  logic        i_stall,
    input  logic        i_flush,
    input  inst_addr_t  i_pc,
    input  data_t       i_result,
    input  data_t       i_data_b,
    input  logic        i_mem_wr_enable,
    input  logic        i_mem_rd_enable,
    input  mem_access_e i_mem_access,
    input  logic        i_mem_unsigned,
    input  reg_addr_t   i_reg_wr_addr,
    input  logic        i_reg_wr_enable,
    input  wb_sel_e     i_reg_wr_data_sel,
    input  logic        i_fetch_req,
    input  inst_addr_t  i_fetch_addr,
    output logic        o_fetch_grant,
    output logic        o_fetch_valid,
    output data_t       o_fetch_data,
    output logic        o_wb_enable,
    output reg_addr_t   o_wb_addr,
    output data_t       o_wb_data,
    output logic        o_misaligned
);

    inst_addr_t  m_pc;                      // EX/MEM outputs
    data_t       m_result;
    data_t       m_data_b;
    logic        m_mem_wr;
    logic        m_mem_rd;
    mem_access_e m_access;
    logic        m_unsigned;
    reg_addr_t   m_rd_addr;
    logic        m_rd_enable;
    wb_sel_e     m_wb_sel;
    logic        data_req;                  // LSU to arbiter
    logic        data_write;
    inst_addr_t  data_index;
    byte_en_t    data_byte_en;
    data_t       data_wdata;
    data_t       data_rdata;
    data_t       load_data;
    logic        ram_enable;                // Arbiter to RAM
    logic        ram_write;
    inst_addr_t  ram_index;
    byte_en_t    ram_byte_en;
    data_t       ram_wdata;
    data_t       ram_rdata;

    pipeline_ex_mem pipeline_ex_mem_inst (
        .i_clock(i_clock), .i_rst_n(i_rst_n), .i_stall(i_stall), .i_flush(i_flush),
        .i_pc(i_pc), .i_result(i_result), .i_data_b(i_data_b),
        .i_mem_wr_enable(i_mem_wr_enable), .i_mem_rd_enable(i_mem_rd_enable),
        .i_mem_access(i_mem_access), .i_mem_unsigned(i_mem_unsigned),
        .i_reg_wr_addr(i_reg_wr_addr), .i_reg_wr_enable(i_reg_wr_enable),
        .i_reg_wr_data_sel(i_reg_wr_data_sel),
        .o_pc(m_pc), .o_result(m_result), .o_data_b(m_data_b),
        .o_mem_wr_enable(m_mem_wr), .o_mem_rd_enable(m_mem_rd),
        .o_mem_access(m_access), .o_mem_unsigned(m_unsigned),
        .o_reg_wr_addr(m_rd_addr), .o_reg_wr_enable(m_rd_enable),
        .o_reg_wr_data_sel(m_wb_sel)
    );

    load_store_unit load_store_unit_inst (
        .i_clock(i_clock), .i_rst_n(i_rst_n), .i_addr(m_result),  // Address from ALU
        .i_store_data(m_data_b), .i_access(m_access), .i_unsigned(m_unsigned),
        .i_rd_enable(m_mem_rd), .i_wr_enable(m_mem_wr), .i_ram_rdata(data_rdata),
        .o_req(data_req), .o_write(data_write), .o_word_index(data_index),
        .o_byte_en(data_byte_en), .o_wdata(data_wdata), .o_load_data(load_data),
        .o_misaligned(o_misaligned)
    );

    mem_arbiter #(.RAM_WORDS(RAM_WORDS)) mem_arbiter_inst (
        .i_clock(i_clock), .i_rst_n(i_rst_n), .i_data_req(data_req),
        .i_data_write(data_write), .i_data_index(data_index),
        .i_data_byte_en(data_byte_en), .i_data_wdata(data_wdata),
        .i_fetch_req(i_fetch_req), .i_fetch_addr(i_fetch_addr), .i_ram_rdata(ram_rdata),
        .o_fetch_grant(o_fetch_grant), .o_fetch_valid(o_fetch_valid),
        .o_fetch_data(o_fetch_data), .o_data_rdata(data_rdata),
        .o_ram_enable(ram_enable), .o_ram_write(ram_write), .o_ram_index(ram_index),
        .o_ram_byte_en(ram_byte_en), .o_ram_wdata(ram_wdata)
    );

    unified_ram #(.RAM_WORDS(RAM_WORDS)) unified_ram_inst (
        .i_clock(i_clock), .i_enable(ram_enable), .i_write(ram_write),
        .i_index(ram_index), .i_byte_en(ram_byte_en), .i_wdata(ram_wdata),
        .o_rdata(ram_rdata)
    );

    writeback_stage writeback_stage_inst (
        .i_clock(i_clock), .i_rst_n(i_rst_n), .i_pc(m_pc), .i_result(m_result),
        .i_reg_wr_addr(m_rd_addr), .i_reg_wr_enable(m_rd_enable),
        .i_reg_wr_data_sel(m_wb_sel), .i_load_data(load_data),
        .o_wb_enable(o_wb_enable), .o_wb_addr(o_wb_addr), .o_wb_data(o_wb_data)
    );

endmodule

`default_nettype wire

//--- testbench/tb_rv_mem_subsystem.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rv_mem_subsystem
    import rv_pkg::*;
();

    localparam int RAM_WORDS   = 1024;
    localparam int N_OPS       = 64 + 20 + 120 + 16 + 8 + 20 + 3;  // Issue cycles of all phases
    localparam int CYCLE_LIMIT = 4 * N_OPS + 50;

    typedef struct packed {
        inst_addr_t  pc;
        data_t       result;                 // ALU result or byte address
        data_t       data_b;                 // Store data
        logic        wr;
        logic        rd;
        mem_access_e acc;
        logic        uns;
        reg_addr_t   rd_addr;
        logic        rd_en;
        wb_sel_e     sel;
    } ex_op_t;

    logic        i_clock = 1'b0;
    logic        i_rst_n = 1'b0;
    logic        i_stall, i_flush, i_mem_wr_enable, i_mem_rd_enable, i_mem_unsigned;
    logic        i_reg_wr_enable, i_fetch_req;
    inst_addr_t  i_pc, i_fetch_addr;
    data_t       i_result, i_data_b;
    mem_access_e i_mem_access;
    reg_addr_t   i_reg_wr_addr;
    wb_sel_e     i_reg_wr_data_sel;
    logic        o_fetch_grant, o_fetch_valid, o_wb_enable, o_misaligned;
    data_t       o_fetch_data, o_wb_data;
    reg_addr_t   o_wb_addr;

    logic [7:0]  shadow [0:255];             // Byte model of the test region
    logic [31:0] lcg_state = 32'd62;
    int          cycle_count = 0;
    ex_op_t      slot;                       // Modelled EX/MEM contents
    ex_op_t      in_op_q;                    // Inputs driven last cycle
    logic        in_stall_q = 1'b0;
    logic        in_flush_q = 1'b0;
    logic        last_grant = 1'b0;
    inst_addr_t  last_faddr = '0;
    logic        exp_wb_en = 1'b0, exp_mis = 1'b0, exp_grant = 1'b0, exp_fetch_valid = 1'b0;
    reg_addr_t   exp_wb_addr = '0;
    data_t       exp_wb_data = '0, exp_fetch_data = '0;

    rv_mem_subsystem #(.RAM_WORDS(RAM_WORDS)) rv_mem_subsystem_inst (.*);

    always #4 i_clock = ~i_clock;            // 8 ns period

    always @(posedge i_clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run went past %0d cycles without finishing", CYCLE_LIMIT);
            $display("TEST FAIL");
            $fatal(1);
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("ERR t=%0t %s got %h exp %h", $time, name, got, exp);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    // Sampled mid-cycle with all outputs settled
    a_wb_enable: assert property (@(negedge i_clock) disable iff (!i_rst_n)
        o_wb_enable == exp_wb_en) else report_mismatch("o_wb_enable", o_wb_enable, exp_wb_en);
    a_wb_addr: assert property (@(negedge i_clock) disable iff (!i_rst_n)
        exp_wb_en |-> o_wb_addr == exp_wb_addr)
        else report_mismatch("o_wb_addr", o_wb_addr, exp_wb_addr);
    a_wb_data: assert property (@(negedge i_clock) disable iff (!i_rst_n)
        exp_wb_en |-> o_wb_data == exp_wb_data)
        else report_mismatch("o_wb_data", o_wb_data, exp_wb_data);
    a_misaligned: assert property (@(negedge i_clock) disable iff (!i_rst_n)
        o_misaligned == exp_mis) else report_mismatch("o_misaligned", o_misaligned, exp_mis);
    a_fetch_grant: assert property (@(negedge i_clock) disable iff (!i_rst_n)
        o_fetch_grant == exp_grant)
        else report_mismatch("o_fetch_grant", o_fetch_grant, exp_grant);
    a_fetch_valid: assert property (@(negedge i_clock) disable iff (!i_rst_n)
        o_fetch_valid == exp_fetch_valid)
        else report_mismatch("o_fetch_valid", o_fetch_valid, exp_fetch_valid);
    a_fetch_data: assert property (@(negedge i_clock) disable iff (!i_rst_n)
        exp_fetch_valid |-> o_fetch_data == exp_fetch_data)
        else report_mismatch("o_fetch_data", o_fetch_data, exp_fetch_data);

    function automatic logic [31:0] rnd();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {8'h00, lcg_state[31:8]};     // Upper bits since low ones cycle fast
    endfunction

    function automatic logic is_misaligned(input ex_op_t s);
        return (s.acc == ACCESS_HALF && s.result[0]) ||
               (s.acc == ACCESS_WORD && s.result[1:0] != 2'b00);
    endfunction

    function automatic data_t shadow_word(input inst_addr_t addr);
        logic [7:0] a;
        a = {addr[7:2], 2'b00};
        return {shadow[a + 8'd3], shadow[a + 8'd2], shadow[a + 8'd1], shadow[a]};  // Little endian
    endfunction

    function automatic data_t load_value(input ex_op_t s);
        logic [7:0]  a;
        logic [15:0] h;
        a = s.result[7:0];
        h = {shadow[a + 8'd1], shadow[a]};
        case (s.acc)
            ACCESS_BYTE: return s.uns ? {24'd0, shadow[a]} : {{24{shadow[a][7]}}, shadow[a]};
            ACCESS_HALF: return s.uns ? {16'd0, h} : {{16{h[15]}}, h};
            default:     return shadow_word(s.result);
        endcase
    endfunction

    task automatic apply_store(input ex_op_t s);
        logic [7:0] a;
        a = s.result[7:0];
        shadow[a] = s.data_b[7:0];
        if (s.acc != ACCESS_BYTE)
            shadow[a + 8'd1] = s.data_b[15:8];
        if (s.acc == ACCESS_WORD) begin
            shadow[a + 8'd2] = s.data_b[23:16];
            shadow[a + 8'd3] = s.data_b[31:24];
        end
    endtask

    function automatic ex_op_t nop_op();
        ex_op_t op;
        op     = '0;
        op.acc = ACCESS_WORD;
        op.sel = WB_RESULT;
        return op;
    endfunction

    function automatic ex_op_t alu_op();
        ex_op_t op;
        op         = nop_op();
        op.pc      = rnd() << 2;
        op.result  = (rnd() << 8) ^ rnd();   // Full 32 bits
        op.rd_addr = reg_addr_t'(rnd());
        op.rd_en   = 1'b1;
        op.sel     = rnd() % 2 ? WB_LINK : WB_RESULT;
        return op;
    endfunction

    function automatic ex_op_t mem_op(input logic wr, input mem_access_e acc,
                                      input inst_addr_t addr, input logic uns);
        ex_op_t op;
        op        = nop_op();
        op.pc     = rnd() << 2;
        op.result = addr;
        op.data_b = (rnd() << 8) ^ rnd();
        op.wr     = wr;
        op.rd     = !wr;
        op.acc    = acc;
        op.uns    = uns;
        if (!wr) begin                       // Loads write back their data
            op.rd_en   = 1'b1;
            op.rd_addr = reg_addr_t'(rnd());
            op.sel     = WB_LOAD;
        end
        return op;
    endfunction

    function automatic inst_addr_t aligned_addr(input mem_access_e acc);
        inst_addr_t a;
        a = rnd() % 256;
        case (acc)
            ACCESS_BYTE: return a;
            ACCESS_HALF: return a & ~32'd1;
            default:     return a & ~32'd3;
        endcase
    endfunction

    task automatic drive_inputs(input ex_op_t op, input logic stall, input logic flush,
                                input logic freq, input inst_addr_t faddr);
        i_pc              = op.pc;
        i_result          = op.result;
        i_data_b          = op.data_b;
        i_mem_wr_enable   = op.wr;
        i_mem_rd_enable   = op.rd;
        i_mem_access      = op.acc;
        i_mem_unsigned    = op.uns;
        i_reg_wr_addr     = op.rd_addr;
        i_reg_wr_enable   = op.rd_en;
        i_reg_wr_data_sel = op.sel;
        i_stall           = stall;
        i_flush           = flush;
        i_fetch_req       = freq;
        i_fetch_addr      = faddr;
    endtask

    // One clock with the edge just taken modelled before the next drive
    task automatic run_cycle(input ex_op_t op, input logic stall, input logic flush,
                             input logic freq, input inst_addr_t faddr);
        ex_op_t old_slot;
        @(posedge i_clock);
        #1;
        old_slot = slot;                     // Accessed memory at this edge
        if (in_flush_q) begin                // Flush wins over stall
            slot       = in_op_q;
            slot.wr    = 1'b0;
            slot.rd    = 1'b0;
            slot.rd_en = 1'b0;
        end else if (!in_stall_q)
            slot = in_op_q;
        exp_wb_en   = old_slot.rd_en && old_slot.rd_addr != 5'd0;  // x0 never written
        exp_wb_addr = old_slot.rd_addr;
        case (old_slot.sel)
            WB_LOAD: exp_wb_data = load_value(old_slot);
            WB_LINK: exp_wb_data = old_slot.pc + 32'd4;
            default: exp_wb_data = old_slot.result;
        endcase
        exp_fetch_valid = last_grant;
        exp_fetch_data  = shadow_word(last_faddr);
        if (old_slot.wr && !is_misaligned(old_slot))
            apply_store(old_slot);
        drive_inputs(op, stall, flush, freq, faddr);
        exp_mis    = (slot.wr || slot.rd) && is_misaligned(slot);
        exp_grant  = freq && !((slot.wr || slot.rd) && !is_misaligned(slot));
        last_grant = exp_grant;
        last_faddr = faddr;
        in_op_q    = op;
        in_stall_q = stall;
        in_flush_q = flush;
    endtask

    initial begin
        ex_op_t      op;
        mem_access_e acc;
        inst_addr_t  addr;
        inst_addr_t  faddr;
        slot    = nop_op();                  // Reset contents of EX/MEM
        in_op_q = nop_op();
        drive_inputs(nop_op(), 1'b0, 1'b0, 1'b0, '0);
        repeat (2) @(posedge i_clock);
        #1 i_rst_n = 1'b1;
        for (int i = 0; i < 64; i++)         // Fill region with known words
            run_cycle(mem_op(1'b1, ACCESS_WORD, i * 4, 1'b0), 1'b0, 1'b0, 1'b0, '0);
        for (int i = 0; i < 20; i++) begin   // ALU and link results
            op = alu_op();
            if (i % 5 == 0)
                op.rd_addr = '0;
            run_cycle(op, 1'b0, 1'b0, 1'b0, '0);
        end
        faddr = (rnd() % 64) * 4;
        for (int i = 0; i < 120; i++) begin  // Loads, stores, ALU with fetch held high
            acc = mem_access_e'(rnd() % 3);
            case (rnd() % 3)
                0:       op = alu_op();
                1:       op = mem_op(1'b1, acc, aligned_addr(acc), 1'b0);
                default: op = mem_op(1'b0, acc, aligned_addr(acc), rnd() % 2);
            endcase
            if (last_grant)                  // New fetch only after a grant
                faddr = (rnd() % 64) * 4;
            run_cycle(op, 1'b0, 1'b0, 1'b1, faddr);
        end
        for (int i = 0; i < 8; i++) begin    // Misaligned access and word read-back
            acc  = i % 2 ? ACCESS_HALF : ACCESS_WORD;
            addr = acc == ACCESS_HALF ? (rnd() % 128) * 2 + 1 : (rnd() % 64) * 4 + 1 + rnd() % 3;
            op       = mem_op(i < 4, acc, addr, 1'b0);
            op.rd_en = 1'b0;
            run_cycle(op, 1'b0, 1'b0, 1'b0, '0);
            run_cycle(mem_op(1'b0, ACCESS_WORD, addr & ~32'd3, 1'b0), 1'b0, 1'b0, 1'b0, '0);
        end
        for (int i = 0; i < 4; i++) begin    // Flushed store with reg write
            addr       = aligned_addr(ACCESS_WORD);
            op         = mem_op(1'b1, ACCESS_WORD, addr, 1'b0);
            op.rd_en   = 1'b1;
            op.rd_addr = 5'd1 + rnd() % 31;
            run_cycle(op, i % 2, 1'b1, 1'b0, '0);
            run_cycle(mem_op(1'b0, ACCESS_WORD, addr, 1'b0), 1'b0, 1'b0, 1'b0, '0);
        end
        for (int i = 0; i < 4; i++) begin    // Store held through a stall
            acc = mem_access_e'(rnd() % 3);
            run_cycle(mem_op(1'b1, acc, aligned_addr(acc), 1'b0), 1'b0, 1'b0, 1'b0, '0);
            for (int j = 0; j < 3; j++)
                run_cycle(alu_op(), 1'b1, 1'b0, 1'b0, '0);
            run_cycle(alu_op(), 1'b0, 1'b0, 1'b0, '0);
        end
        for (int i = 0; i < 3; i++)          // Drain the pipeline
            run_cycle(nop_op(), 1'b0, 1'b0, 1'b0, '0);
        @(negedge i_clock);
        #1;
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
hdl/rv_pkg.sv
hdl/pipeline_ex_mem.sv
hdl/load_store_unit.sv
hdl/mem_arbiter.sv
hdl/unified_ram.sv
hdl/writeback_stage.sv
hdl/rv_mem_subsystem.sv
testbench/tb_rv_mem_subsystem.sv
